// ==== memsys_consts.svh ====
`ifndef MEMSYS_CONSTS_SVH
`define MEMSYS_CONSTS_SVH

// ----------------------------------------
// Pipeline widths
// ----------------------------------------

`define MEMSYS_XLEN      64
`define MEMSYS_ADDR_W    64

// PC held by pipeline registers out of reset
`define MEMSYS_RESET_PC  64'h0000_0000_8000_0000

// ----------------------------------------
// Data RAM
// ----------------------------------------

`define MEMSYS_RAM_WORDS 256  // 64-bit words
`define MEMSYS_RAM_WAIT  1    // Extra access cycles before pready

`endif

// ==== memsys_pkg.sv ====
`default_nettype none

`include "memsys_consts.svh"

package memsys_pkg;

    // Access size, log2 of the byte count
    typedef enum logic [1:0] {
        MEM_B = 2'd0,
        MEM_H = 2'd1,
        MEM_W = 2'd2,
        MEM_D = 2'd3
    } mem_size_e;

    // Register result source
    typedef enum logic [1:0] {
        RF_ALU  = 2'd0,
        RF_LOAD = 2'd1,
        RF_PC4  = 2'd2
    } rf_src_e;

    typedef struct packed {
        logic      ena;          // Access requested
        logic      wen;          // Store
        mem_size_e size;
        logic      unsigned_ld;  // Zero-extend load
    } mem_ctl_t;

    // ----------------------------------------
    // Stage bundles
    // ----------------------------------------

    typedef struct packed {
        logic                      valid;
        logic [`MEMSYS_ADDR_W-1:0] pc;
        logic [31:0]               inst;
        logic [`MEMSYS_XLEN-1:0]   alu_result;  // Address for loads and stores
        logic [`MEMSYS_XLEN-1:0]   rf_rdata2;   // Store data
        mem_ctl_t                  ctl;
        rf_src_e                   rf_src;
        logic                      rf_we;
        logic [4:0]                rf_waddr;
        logic                      sys;
    } ex_mem_t;

    typedef struct packed {
        logic                      valid;
        logic [`MEMSYS_ADDR_W-1:0] pc;
        logic [31:0]               inst;
        logic [`MEMSYS_XLEN-1:0]   alu_result;
        logic [`MEMSYS_XLEN-1:0]   load_data;
        rf_src_e                   rf_src;
        logic                      rf_we;
        logic [4:0]                rf_waddr;
        logic                      sys;
    } mem_wb_t;

    typedef struct packed {
        logic                      valid;
        logic [`MEMSYS_ADDR_W-1:0] pc;
        logic [31:0]               inst;
        logic                      rf_we;
        logic [4:0]                rf_waddr;
        logic [`MEMSYS_XLEN-1:0]   rf_wdata;
        logic                      sys;
    } commit_t;

    // APB master request, responses travel separately
    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`MEMSYS_ADDR_W-1:0]  paddr;
        logic [`MEMSYS_XLEN-1:0]    pwdata;
        logic [`MEMSYS_XLEN/8-1:0]  pstrb;
    } apb_req_t;

endpackage

`default_nettype wire

// ==== ex_mem_reg.sv ====
`default_nettype none

`include "memsys_consts.svh"

module ex_mem_reg
    import memsys_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    ena,
    input  ex_mem_t ex_in,
    output ex_mem_t ex_mem_q
);

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem_q.valid           <= 1'b0;
            ex_mem_q.pc              <= `MEMSYS_RESET_PC;
            ex_mem_q.inst            <= '0;
            ex_mem_q.alu_result      <= '0;
            ex_mem_q.rf_rdata2       <= '0;
            ex_mem_q.ctl.ena         <= 1'b0;
            ex_mem_q.ctl.wen         <= 1'b0;
            ex_mem_q.ctl.size        <= MEM_B;
            ex_mem_q.ctl.unsigned_ld <= 1'b0;
            ex_mem_q.rf_src          <= RF_ALU;
            ex_mem_q.rf_we           <= 1'b0;
            ex_mem_q.rf_waddr        <= '0;
            ex_mem_q.sys             <= 1'b0;
        end else if (ena) begin
            ex_mem_q <= ex_in;
        end
        // Holds while a memory access is pending
    end

endmodule

`default_nettype wire

// ==== mem_access.sv ====
`default_nettype none

`include "memsys_consts.svh"

module mem_access
    import memsys_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  ex_mem_t                 ex_mem_q,
    output apb_req_t                apb_req,
    input  logic [`MEMSYS_XLEN-1:0] prdata,
    input  logic                    pready,
    output logic                    stall,
    output logic                    mem_done,
    output logic [`MEMSYS_XLEN-1:0] load_data
);

    localparam int LANES = `MEMSYS_XLEN / 8;
    localparam int OFF_W = $clog2(LANES);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } state_e;

    state_e state_q;
    state_e state_d;
    state_e phase;  // Bus phase seen this cycle

    logic                    mem_op;
    logic [OFF_W-1:0]        byte_off;
    logic [OFF_W+2:0]        bit_shift;
    logic [LANES-1:0]        strb_base;
    logic [`MEMSYS_XLEN-1:0] rd_lane;
    logic                    ext_bit;

    assign mem_op    = ex_mem_q.valid && ex_mem_q.ctl.ena;
    assign byte_off  = ex_mem_q.alu_result[OFF_W-1:0];
    assign bit_shift = {byte_off, 3'b000};

    // ----------------------------------------
    // Transfer FSM
    // ----------------------------------------

    always_comb begin
        phase = state_q;
        if (state_q == ST_IDLE && mem_op)
            phase = ST_SETUP;  // Setup starts in the cycle the op arrives

        state_d = state_q;
        case (phase)
            ST_SETUP:  state_d = ST_ACCESS;
            ST_ACCESS: if (pready) state_d = ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    assign mem_done = (phase == ST_ACCESS) && pready;
    assign stall    = mem_op && !mem_done;

    // ----------------------------------------
    // Store alignment
    // ----------------------------------------

    always_comb begin
        case (ex_mem_q.ctl.size)
            MEM_B: strb_base = LANES'(8'h01);
            MEM_H: strb_base = LANES'(8'h03);
            MEM_W: strb_base = LANES'(8'h0f);
            MEM_D: strb_base = LANES'(8'hff);
        endcase
    end

    always_comb begin
        apb_req.psel    = (phase != ST_IDLE);
        apb_req.penable = (phase == ST_ACCESS);
        apb_req.pwrite  = ex_mem_q.ctl.wen;
        apb_req.paddr   = ex_mem_q.alu_result;
        apb_req.pwdata  = ex_mem_q.rf_rdata2 << bit_shift;
        apb_req.pstrb   = ex_mem_q.ctl.wen ? (strb_base << byte_off) : '0;  // No strobes on reads
    end

    // ----------------------------------------
    // Load extraction
    // ----------------------------------------

    assign rd_lane = prdata >> bit_shift;

    always_comb begin
        case (ex_mem_q.ctl.size)
            MEM_B: ext_bit = rd_lane[7];
            MEM_H: ext_bit = rd_lane[15];
            MEM_W: ext_bit = rd_lane[31];
            MEM_D: ext_bit = rd_lane[63];
        endcase
        if (ex_mem_q.ctl.unsigned_ld)
            ext_bit = 1'b0;

        case (ex_mem_q.ctl.size)
            MEM_B: load_data = {{(`MEMSYS_XLEN-8){ext_bit}}, rd_lane[7:0]};
            MEM_H: load_data = {{(`MEMSYS_XLEN-16){ext_bit}}, rd_lane[15:0]};
            MEM_W: load_data = {{(`MEMSYS_XLEN-32){ext_bit}}, rd_lane[31:0]};
            MEM_D: load_data = rd_lane;
        endcase
    end

endmodule

`default_nettype wire

// ==== apb_data_ram.sv ====
`default_nettype none

`include "memsys_consts.svh"

module apb_data_ram
    import memsys_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  apb_req_t                apb_req,
    output logic [`MEMSYS_XLEN-1:0] prdata,
    output logic                    pready
);

    localparam int LANES = `MEMSYS_XLEN / 8;
    localparam int OFF_W = $clog2(LANES);
    localparam int IDX_W = $clog2(`MEMSYS_RAM_WORDS);
    localparam logic [7:0] WAIT_CYC = `MEMSYS_RAM_WAIT;

    logic [`MEMSYS_XLEN-1:0] mem [`MEMSYS_RAM_WORDS];

    logic [IDX_W-1:0] idx;
    logic             access;
    logic [7:0]       wait_cnt;

    // Word index wraps at the RAM depth
    assign idx    = apb_req.paddr[OFF_W +: IDX_W];
    assign access = apb_req.psel && apb_req.penable;

    // ----------------------------------------
    // Wait states
    // ----------------------------------------

    assign pready = access && (wait_cnt == WAIT_CYC);

    always_ff @(posedge clk) begin
        if (rst)
            wait_cnt <= '0;
        else if (access && !pready)
            wait_cnt <= wait_cnt + 8'd1;
        else
            wait_cnt <= '0;  // Rearm for next transfer
    end

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (access && pready && apb_req.pwrite) begin
            for (int i = 0; i < LANES; i++) begin
                if (apb_req.pstrb[i])
                    mem[idx][i*8 +: 8] <= apb_req.pwdata[i*8 +: 8];
            end
        end
    end

    assign prdata = apb_req.psel ? mem[idx] : '0;

endmodule

`default_nettype wire

// ==== mem_wb_reg.sv ====
`default_nettype none

`include "memsys_consts.svh"

module mem_wb_reg
    import memsys_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  ex_mem_t                 ex_mem_q,
    input  logic                    stall,
    input  logic                    mem_done,
    input  logic [`MEMSYS_XLEN-1:0] load_data,
    output commit_t                 commit
);

    localparam logic [`MEMSYS_ADDR_W-1:0] PC_STEP = 4;

    mem_wb_t wb_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_q.valid      <= 1'b0;
            wb_q.pc         <= `MEMSYS_RESET_PC;
            wb_q.inst       <= '0;
            wb_q.alu_result <= '0;
            wb_q.load_data  <= '0;
            wb_q.rf_src     <= RF_ALU;
            wb_q.rf_we      <= 1'b0;
            wb_q.rf_waddr   <= '0;
            wb_q.sys        <= 1'b0;
        end else begin
            wb_q.valid      <= ex_mem_q.valid && !stall;  // Bubble while stalled
            wb_q.pc         <= ex_mem_q.pc;
            wb_q.inst       <= ex_mem_q.inst;
            wb_q.alu_result <= ex_mem_q.alu_result;
            wb_q.load_data  <= mem_done ? load_data : '0;
            wb_q.rf_src     <= ex_mem_q.rf_src;
            wb_q.rf_we      <= ex_mem_q.valid && ex_mem_q.rf_we && !stall;
            wb_q.rf_waddr   <= ex_mem_q.rf_waddr;
            wb_q.sys        <= ex_mem_q.sys;
        end
    end

    // ----------------------------------------
    // Writeback select
    // ----------------------------------------

    always_comb begin
        commit.valid    = wb_q.valid;
        commit.pc       = wb_q.pc;
        commit.inst     = wb_q.inst;
        commit.rf_we    = wb_q.rf_we && (wb_q.rf_waddr != 5'd0);  // x0 never written
        commit.rf_waddr = wb_q.rf_waddr;
        commit.sys      = wb_q.sys;
        case (wb_q.rf_src)
            RF_LOAD: commit.rf_wdata = wb_q.load_data;
            RF_PC4:  commit.rf_wdata = wb_q.pc + PC_STEP;
            default: commit.rf_wdata = wb_q.alu_result;
        endcase
    end

endmodule

`default_nettype wire

// ==== memsys_top.sv ====
`default_nettype none

`include "memsys_consts.svh"

module memsys_top
    import memsys_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  ex_mem_t ex_in,
    output logic    stall,
    output commit_t commit
);

    ex_mem_t                 ex_mem_q;
    apb_req_t                apb_req;
    logic [`MEMSYS_XLEN-1:0] prdata;
    logic                    pready;
    logic [`MEMSYS_XLEN-1:0] load_data;
    logic                    mem_done;

    ex_mem_reg u_ex_mem_reg (
        .clk      (clk),
        .rst      (rst),
        .ena      (!stall),  // Upstream frozen during APB access
        .ex_in    (ex_in),
        .ex_mem_q (ex_mem_q)
    );

    mem_access u_mem_access (
        .clk       (clk),
        .rst       (rst),
        .ex_mem_q  (ex_mem_q),
        .apb_req   (apb_req),
        .prdata    (prdata),
        .pready    (pready),
        .stall     (stall),
        .mem_done  (mem_done),
        .load_data (load_data)
    );

    apb_data_ram u_apb_data_ram (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .prdata  (prdata),
        .pready  (pready)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk       (clk),
        .rst       (rst),
        .ex_mem_q  (ex_mem_q),
        .stall     (stall),
        .mem_done  (mem_done),
        .load_data (load_data),
        .commit    (commit)
    );

endmodule

`default_nettype wire

// ==== tb_memsys.sv ====
`default_nettype none

`include "memsys_consts.svh"

module tb_memsys
    import memsys_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAM_BYTES = `MEMSYS_RAM_WORDS * 8;
    localparam int TIMEOUT   = 50;  // Cycles

    logic    clk = 1'b0;
    logic    rst;
    ex_mem_t ex_in;
    logic    stall;
    commit_t commit;

    logic [7:0] shadow [RAM_BYTES];  // Byte image of the data RAM
    commit_t    exp_q[$];
    int         exp_cyc_q[$];        // Commit cycle, -1 for memory ops

    int cycle       = 0;
    int mem_pending = 0;
    int n_checked   = 0;
    int n_mismatch  = 0;
    int n_other     = 0;
    bit hung        = 1'b0;

    memsys_top DUT (
        .clk    (clk),
        .rst    (rst),
        .ex_in  (ex_in),
        .stall  (stall),
        .commit (commit)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    function automatic logic [63:0] align_addr(logic [63:0] a, mem_size_e s);
        return a & ~((64'd1 << s) - 64'd1);
    endfunction

    function automatic logic [63:0] shadow_read(logic [63:0] addr, mem_size_e s, logic uns);
        int          idx;
        int          nbytes;
        logic [63:0] val;
        logic        sign;
        idx    = int'(addr[10:0]);
        nbytes = 1 << int'(s);
        val    = '0;
        for (int i = 0; i < nbytes; i++)
            val[i*8 +: 8] = shadow[idx + i];  // Little endian
        sign = !uns && val[nbytes*8 - 1];
        for (int i = nbytes * 8; i < 64; i++)
            val[i] = sign;
        return val;
    endfunction

    function automatic void shadow_write(logic [63:0] addr, mem_size_e s, logic [63:0] data);
        int idx;
        idx = int'(addr[10:0]);
        for (int i = 0; i < (1 << int'(s)); i++)
            shadow[idx + i] = data[i*8 +: 8];
    endfunction

    function automatic commit_t expected_commit(ex_mem_t in);
        commit_t c;
        c.valid    = 1'b1;
        c.pc       = in.pc;
        c.inst     = in.inst;
        c.rf_we    = in.rf_we && (in.rf_waddr != 5'd0);
        c.rf_waddr = in.rf_waddr;
        c.sys      = in.sys;
        case (in.rf_src)
            RF_LOAD: c.rf_wdata = shadow_read(in.alu_result, in.ctl.size, in.ctl.unsigned_ld);
            RF_PC4:  c.rf_wdata = in.pc + 64'd4;
            default: c.rf_wdata = in.alu_result;
        endcase
        if (in.ctl.ena && in.ctl.wen)
            shadow_write(in.alu_result, in.ctl.size, in.rf_rdata2);
        return c;
    endfunction

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    function automatic bit chance(int unsigned pct);
        return ($urandom % 32'd100) < pct;
    endfunction

    function automatic ex_mem_t random_instr(int unsigned mem_pct, int unsigned bubble_pct);
        ex_mem_t     in;
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] lo;
        r  = $urandom;
        hi = $urandom;
        lo = $urandom;
        in.valid           = !chance(bubble_pct);
        in.pc              = {hi, lo[31:2], 2'b00};
        in.inst            = $urandom;
        in.alu_result      = {$urandom, $urandom};
        in.rf_rdata2       = {$urandom, $urandom};
        in.ctl.ena         = chance(mem_pct);
        in.ctl.wen         = r[0];
        in.ctl.size        = mem_size_e'(r[2:1]);
        in.ctl.unsigned_ld = r[3];
        in.sys             = r[4];
        in.rf_waddr        = (r[15:13] == 3'd0) ? 5'd0 : r[9:5];  // x0 fairly often
        if (in.ctl.ena)
            in.alu_result = align_addr(in.alu_result, in.ctl.size);
        if (in.ctl.ena && !in.ctl.wen) begin
            in.rf_src = RF_LOAD;
            in.rf_we  = 1'b1;
        end else begin
            in.rf_src = r[10] ? RF_PC4 : RF_ALU;
            in.rf_we  = r[11] | r[12];
        end
        return in;
    endfunction

    // Drives one instruction at a falling edge where the next rising edge accepts it
    task automatic send(ex_mem_t in);
        int waited;
        waited = 0;
        if (hung)
            return;
        @(negedge clk);
        while (stall && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (stall) begin
            $display("Timeout at %0t: stall stayed high for %0d cycles", $time, TIMEOUT);
            n_other++;
            hung = 1'b1;
            return;
        end
        ex_in = in;
        if (in.valid) begin
            exp_q.push_back(expected_commit(in));
            if (in.ctl.ena) begin
                exp_cyc_q.push_back(-1);
                mem_pending++;
            end else begin
                exp_cyc_q.push_back(cycle + 2);
            end
        end
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    task automatic report_mismatch(string what, logic [63:0] got, logic [63:0] exp);
        n_mismatch++;
        $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    task automatic compare_flag(logic got, logic exp, string what);
        n_checked++;
        if (got !== exp)
            report_mismatch(what, 64'(got), 64'(exp));
    endtask

    task automatic compare_commit(commit_t got, commit_t exp);
        n_checked++;
        if (got.pc !== exp.pc)
            report_mismatch("commit.pc", got.pc, exp.pc);
        if (got.inst !== exp.inst)
            report_mismatch("commit.inst", 64'(got.inst), 64'(exp.inst));
        if (got.rf_we !== exp.rf_we)
            report_mismatch("commit.rf_we", 64'(got.rf_we), 64'(exp.rf_we));
        if (got.rf_waddr !== exp.rf_waddr)
            report_mismatch("commit.rf_waddr", 64'(got.rf_waddr), 64'(exp.rf_waddr));
        if (got.rf_wdata !== exp.rf_wdata)
            report_mismatch("commit.rf_wdata", got.rf_wdata, exp.rf_wdata);
        if (got.sys !== exp.sys)
            report_mismatch("commit.sys", 64'(got.sys), 64'(exp.sys));
    endtask

    always @(negedge clk) begin : monitor
        commit_t exp;
        int      exp_cyc;
        if (rst) begin
            compare_flag(commit.valid, 1'b0, "commit.valid in reset");
            compare_flag(commit.rf_we, 1'b0, "commit.rf_we in reset");
            compare_flag(stall, 1'b0, "stall in reset");
        end else begin
            if (!commit.valid) begin
                compare_flag(commit.rf_we, 1'b0, "commit.rf_we on bubble");
            end else if (exp_q.size() == 0) begin
                $display("Error at %0t: commit with no instruction outstanding", $time);
                n_other++;
            end else begin
                exp     = exp_q.pop_front();
                exp_cyc = exp_cyc_q.pop_front();
                compare_commit(commit, exp);
                if (exp_cyc < 0)
                    mem_pending--;
                else if (cycle != exp_cyc)
                    report_mismatch("commit cycle", 64'(cycle), 64'(exp_cyc));
            end
            if (stall && mem_pending == 0) begin
                $display("Error at %0t: stall high with no memory instruction pending", $time);
                n_other++;
            end
        end
    end

    initial begin
        ex_mem_t in;
        int      waited;
        void'($urandom(32'h8e0cc49f));
        rst   = 1'b1;
        ex_in = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Every word written once before any load
        for (int w = 0; w < `MEMSYS_RAM_WORDS; w++) begin
            in               = random_instr(100, 0);
            in.ctl.wen       = 1'b1;
            in.ctl.size      = MEM_D;
            in.alu_result    = {$urandom, 21'd0, w[7:0], 3'b000};
            in.rf_src        = RF_ALU;
            send(in);
        end

        in          = random_instr(0, 0);
        in.rf_waddr = 5'd0;
        in.rf_we    = 1'b1;
        in.sys      = 1'b1;
        send(in);
        for (int i = 0; i < 16; i++)
            send(random_instr(0, 0));

        // Store then load back, all sizes and both extensions
        for (int i = 0; i < 64; i++) begin
            in                 = random_instr(100, 0);
            in.ctl.wen         = 1'b1;
            in.ctl.size        = mem_size_e'(i[1:0]);
            in.alu_result      = align_addr(in.alu_result, in.ctl.size);
            in.rf_src          = RF_ALU;
            send(in);
            in.ctl.wen         = 1'b0;
            in.ctl.unsigned_ld = i[2];
            in.rf_src          = RF_LOAD;
            in.rf_we           = 1'b1;
            send(in);
        end

        for (int i = 0; i < 32; i++)
            send(random_instr(100, 10));  // Back-to-back memory ops
        for (int i = 0; i < 400; i++)
            send(random_instr(40, 20));

        in       = random_instr(0, 0);
        in.valid = 1'b0;
        send(in);

        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d commits never arrived", exp_q.size());
            n_other++;
        end
        repeat (4) @(negedge clk);

        $display("checks=%0d mismatches=%0d other errors=%0d", n_checked, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== memsys.f ====
+incdir+.
memsys_pkg.sv
ex_mem_reg.sv
mem_access.sv
apb_data_ram.sv
mem_wb_reg.sv
memsys_top.sv
tb_memsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --top-module tb_memsys -f memsys.f -o tb_memsys > build.log 2>&1 \
    && ./obj_dir/tb_memsys > sim.log 2>&1

grep -qx "TEST OK" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
